// File: tb.f
rtl/mem_bus_pkg.sv
rtl/display_pkg.sv
rtl/request_handler.sv
rtl/wait_state_sram.sv
rtl/frame_fetcher.sv
rtl/uart_rx_buffer.sv
rtl/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv

// File: verif/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem;
    import mem_bus_pkg::*;
    import display_pkg::*;

    localparam addr_t       UART_ADDRESS   = 32'd500;
    localparam int          MEM_WORDS      = 1024;
    localparam int          WAIT_STATES    = 2;
    localparam addr_t       FB_BASE        = 32'h400;
    localparam int          FRAME_WORDS    = 24;
    localparam int          FIFO_DEPTH     = 4;
    localparam int          RX_DEPTH       = 4;
    localparam int          AW             = $clog2(MEM_WORDS);
    localparam int          RESET_CYCLES   = 4;
    localparam int          GAP_BOUND      = 8 * (WAIT_STATES + 1);
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam int          DATA_ADDRS     = 12;
    localparam int unsigned SEED           = 32'hd3409bd6;

    logic       clk = 1'b0;
    logic       nRst;
    cpu_req_t   cpu_req;
    logic       frame_start;
    logic       pix_ready = 1'b0;
    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       cpu_enable;
    word_t      instr_data_to_cpu;
    word_t      data_to_cpu;
    logic       pix_valid;
    pix_word_t  pix_data;
    logic       rx_ready;

    // reference models
    word_t       shadow [MEM_WORDS];
    logic [7:0]  rx_queue [$];
    logic        rx_exp_nonempty = 1'b0;
    logic [7:0]  rx_exp_head = 8'h00;
    int unsigned pix_cnt = 0;
    int unsigned frames_started = 0;
    int unsigned gap_cnt = 0;
    int unsigned cycle = 0;
    logic        pix_random = 1'b0;
    logic        pix_level = 1'b0;
    addr_t       cur_instr_adr = '0;
    int unsigned item_cnt = 0;
    addr_t       data_addrs [DATA_ADDRS];
    word_t       exp_data_word;
    word_t       exp_instr_word;
    word_t       exp_pix_word;
    logic        uart_read;

    mem_subsystem_top #(
        .UART_ADDRESS(UART_ADDRESS),
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES),
        .FB_BASE     (FB_BASE),
        .FRAME_WORDS (FRAME_WORDS),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .RX_DEPTH    (RX_DEPTH)
    ) dut0 (
        .clk              (clk),
        .nRst             (nRst),
        .cpu_req          (cpu_req),
        .frame_start      (frame_start),
        .pix_ready        (pix_ready),
        .rx_valid         (rx_valid),
        .rx_byte          (rx_byte),
        .cpu_enable       (cpu_enable),
        .instr_data_to_cpu(instr_data_to_cpu),
        .data_to_cpu      (data_to_cpu),
        .pix_valid        (pix_valid),
        .pix_data         (pix_data),
        .rx_ready         (rx_ready)
    );

    always #2 clk = ~clk;

    assign exp_data_word  = shadow[cpu_req.data_adr[AW+1:2]];
    assign exp_instr_word = shadow[cpu_req.instr_adr[AW+1:2]];
    assign exp_pix_word   = shadow[(FB_BASE >> 2) + (pix_cnt % FRAME_WORDS)];
    assign uart_read      = cpu_enable && cpu_req.read && (cpu_req.data_adr == UART_ADDRESS);

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic cpu_req_t write_req(addr_t adr, word_t data, sel_t sel);
        cpu_req_t r;
        r          = '0;
        r.data_adr = adr;
        r.write    = 1'b1;
        r.wdata    = data;
        r.sel      = sel;
        return r;
    endfunction

    function automatic cpu_req_t read_req(addr_t adr);
        cpu_req_t r;
        r          = '0;
        r.data_adr = adr;
        r.read     = 1'b1;
        return r;
    endfunction

    // hand over the next request once the current one ends
    task automatic cpu_access(input cpu_req_t req);
        cpu_req_t r;
        r = req;
        do @(posedge clk); while (!cpu_enable);
        r.instr_adr = cur_instr_adr;
        cpu_req <= r;
        item_cnt++;
        // fetch address moves every fourth item
        if (item_cnt % 4 == 0) begin
            cur_instr_adr = addr_t'(4 * ($urandom % 8));
        end
    endtask

    task automatic push_rx(input logic [7:0] b);
        rx_valid <= 1'b1;
        rx_byte  <= b;
        do @(posedge clk); while (!rx_ready);
        rx_valid <= 1'b0;
    endtask

    task automatic pulse_frame();
        frame_start    <= 1'b1;
        frames_started <= frames_started + 1;
        @(posedge clk);
        frame_start <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (pix_random) begin
            pix_ready <= ($urandom % 4) != 0;
        end else begin
            pix_ready <= pix_level;
        end
    end

    // shadow memory, uart byte mirror and pixel count
    always @(posedge clk) begin
        if (nRst) begin
            if (cpu_enable) begin
                if (cpu_req.write && cpu_req.data_adr != UART_ADDRESS) begin
                    for (int i = 0; i < 4; i++) begin
                        if (cpu_req.sel[i]) begin
                            shadow[cpu_req.data_adr[AW+1:2]][8*i +: 8] <= cpu_req.wdata[8*i +: 8];
                        end
                    end
                end
            end
            if (uart_read && rx_queue.size() != 0) begin
                void'(rx_queue.pop_front());
            end
            if (rx_valid && rx_ready) begin
                rx_queue.push_back(rx_byte);
            end
            if (pix_valid && pix_ready) begin
                pix_cnt <= pix_cnt + 1;
            end
        end
        rx_exp_nonempty <= (rx_queue.size() != 0);
        rx_exp_head     <= (rx_queue.size() != 0) ? rx_queue[0] : 8'h00;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!nRst || cpu_enable) begin
            gap_cnt <= 0;
        end else begin
            gap_cnt <= gap_cnt + 1;
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    a_reset_state: assert property (
        @(posedge clk) (cycle >= 1 && cycle <= RESET_CYCLES)
        |-> (!cpu_enable && !pix_valid && rx_ready)
    ) else begin
        $display("error %0t cpu_enable/pix_valid/rx_ready expected 0/0/1 got %b/%b/%b", $time,
                 $sampled(cpu_enable), $sampled(pix_valid), $sampled(rx_ready));
        stop_on_error();
    end

    a_data_word: assert property (
        @(posedge clk) disable iff (!nRst)
        (cpu_enable && cpu_req.read && cpu_req.data_adr != UART_ADDRESS)
        |-> (data_to_cpu === exp_data_word)
    ) else begin
        $display("error %0t data_to_cpu expected %h got %h", $time,
                 $sampled(exp_data_word), $sampled(data_to_cpu));
        stop_on_error();
    end

    // fetch word at the address of the request that cpu_enable ends
    a_instr_word: assert property (
        @(posedge clk) disable iff (!nRst)
        cpu_enable |-> (instr_data_to_cpu === exp_instr_word)
    ) else begin
        $display("error %0t instr_data_to_cpu expected %h got %h", $time,
                 $sampled(exp_instr_word), $sampled(instr_data_to_cpu));
        stop_on_error();
    end

    a_uart_byte: assert property (
        @(posedge clk) disable iff (!nRst)
        (uart_read && rx_exp_nonempty) |-> (data_to_cpu === {1'b1, 23'd0, rx_exp_head})
    ) else begin
        $display("error %0t data_to_cpu expected %h got %h", $time,
                 {1'b1, 23'd0, $sampled(rx_exp_head)}, $sampled(data_to_cpu));
        stop_on_error();
    end

    a_uart_empty: assert property (
        @(posedge clk) disable iff (!nRst)
        (uart_read && !rx_exp_nonempty) |-> !data_to_cpu[31]
    ) else begin
        $display("error %0t data_to_cpu[31] expected 0 got %b", $time, $sampled(data_to_cpu[31]));
        stop_on_error();
    end

    a_pix_word: assert property (
        @(posedge clk) disable iff (!nRst) (pix_valid && pix_ready) |-> (pix_data === exp_pix_word)
    ) else begin
        $display("error %0t pix_data expected %h got %h", $time,
                 $sampled(exp_pix_word), $sampled(pix_data));
        stop_on_error();
    end

    a_pix_count: assert property (
        @(posedge clk) disable iff (!nRst)
        (pix_valid && pix_ready) |-> (pix_cnt < FRAME_WORDS * frames_started)
    ) else begin
        $display("error %0t pixel transfers expected at most %0d got %0d", $time,
                 FRAME_WORDS * $sampled(frames_started), $sampled(pix_cnt) + 1);
        stop_on_error();
    end

    a_no_starve: assert property (
        @(posedge clk) disable iff (!nRst) gap_cnt <= GAP_BOUND
    ) else begin
        $display("error %0t cpu_enable gap expected at most %0d got %0d", $time,
                 GAP_BOUND, $sampled(gap_cnt));
        stop_on_error();
    end

    initial begin
        void'($urandom(SEED));
        nRst        = 1'b0;
        cpu_req     = '0;
        frame_start = 1'b0;
        rx_valid    = 1'b0;
        rx_byte     = 8'h00;
        repeat (RESET_CYCLES) @(posedge clk);
        nRst <= 1'b1;

        // instruction words
        for (int i = 0; i < 8; i++) begin
            cpu_access(write_req(addr_t'(4 * i), $urandom, 4'hf));
        end

        // full write then a partial write per address, read back afterwards
        for (int i = 0; i < DATA_ADDRS; i++) begin
            data_addrs[i] = addr_t'(4 * (32 + $urandom % 64));
            cpu_access(write_req(data_addrs[i], $urandom, 4'hf));
            cpu_access(write_req(data_addrs[i], $urandom, sel_t'($urandom)));
        end
        for (int i = 0; i < DATA_ADDRS; i++) begin
            cpu_access(read_req(data_addrs[i]));
        end

        // uart bypass, last read finds the buffer empty
        cpu_access('0);
        for (int i = 0; i < 3; i++) begin
            push_rx(8'($urandom));
        end
        for (int i = 0; i < 4; i++) begin
            cpu_access(read_req(UART_ADDRESS));
        end
        // alias of the uart word in memory must survive a uart write
        cpu_access(write_req(UART_ADDRESS + 4 * MEM_WORDS, $urandom, 4'hf));
        cpu_access(write_req(UART_ADDRESS, $urandom, 4'hf));
        cpu_access(read_req(UART_ADDRESS + 4 * MEM_WORDS));

        // frame buffer contents
        for (int i = 0; i < FRAME_WORDS; i++) begin
            cpu_access(write_req(addr_t'(FB_BASE + 4 * i), $urandom, 4'hf));
        end
        cpu_access('0);

        pix_random <= 1'b1;
        pulse_frame();
        while (pix_cnt < FRAME_WORDS) begin
            cpu_access(read_req(data_addrs[$urandom % DATA_ADDRS]));
        end
        pix_random <= 1'b0;
        repeat (8) cpu_access('0);

        // second frame stalled by the display side
        pulse_frame();
        repeat (30) cpu_access(read_req(data_addrs[$urandom % DATA_ADDRS]));
        pix_level <= 1'b1;
        while (pix_cnt < 2 * FRAME_WORDS) begin
            cpu_access('0);
        end
        repeat (4) cpu_access('0);

        if (pix_cnt != 2 * FRAME_WORDS || rx_queue.size() != 0) begin
            $display("error %0t pixel count expected %0d got %0d, uart bytes left %0d", $time,
                     2 * FRAME_WORDS, pix_cnt, rx_queue.size());
            stop_on_error();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top #(
    parameter mem_bus_pkg::addr_t UART_ADDRESS = 32'd500,
    parameter int                 MEM_WORDS    = 1024,
    parameter int                 WAIT_STATES  = 2,
    parameter mem_bus_pkg::addr_t FB_BASE      = 32'h400,
    parameter int                 FRAME_WORDS  = 24,
    parameter int                 FIFO_DEPTH   = 4,
    parameter int                 RX_DEPTH     = 4
) (
    input  logic                   clk,
    input  logic                   nRst,
    input  mem_bus_pkg::cpu_req_t  cpu_req,
    input  logic                   frame_start,
    input  logic                   pix_ready,
    input  logic                   rx_valid,
    input  logic [7:0]             rx_byte,
    output logic                   cpu_enable,
    output mem_bus_pkg::word_t     instr_data_to_cpu,
    output mem_bus_pkg::word_t     data_to_cpu,
    output logic                   pix_valid,
    output display_pkg::pix_word_t pix_data,
    output logic                   rx_ready
);
    import mem_bus_pkg::*;
    import display_pkg::*;

    // shared memory port
    mem_req_t   mem_req;
    logic       mem_busy;
    word_t      mem_rdata;

    // display fetcher to handler
    vga_state_t vga_state;
    logic       vga_read;
    addr_t      vga_adr;
    word_t      data_to_vga;
    logic       vga_enable;

    // uart buffer to handler
    word_t      uart_word;
    logic       uart_pop;

    request_handler #(
        .UART_ADDRESS(UART_ADDRESS)
    ) u_handler (
        .clk              (clk),
        .nRst             (nRst),
        .mem_busy         (mem_busy),
        .mem_rdata        (mem_rdata),
        .mem_req          (mem_req),
        .vga_state        (vga_state),
        .vga_read         (vga_read),
        .vga_adr          (vga_adr),
        .data_to_vga      (data_to_vga),
        .vga_enable       (vga_enable),
        .cpu_req          (cpu_req),
        .instr_data_to_cpu(instr_data_to_cpu),
        .data_to_cpu      (data_to_cpu),
        .cpu_enable       (cpu_enable),
        .uart_word        (uart_word),
        .uart_pop         (uart_pop)
    );

    wait_state_sram #(
        .MEM_WORDS  (MEM_WORDS),
        .WAIT_STATES(WAIT_STATES)
    ) u_sram (
        .clk      (clk),
        .nRst     (nRst),
        .mem_req  (mem_req),
        .mem_busy (mem_busy),
        .mem_rdata(mem_rdata)
    );

    frame_fetcher #(
        .FB_BASE    (FB_BASE),
        .FRAME_WORDS(FRAME_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fetcher (
        .clk        (clk),
        .nRst       (nRst),
        .frame_start(frame_start),
        .vga_enable (vga_enable),
        .data_to_vga(data_to_vga),
        .pix_ready  (pix_ready),
        .vga_state  (vga_state),
        .vga_read   (vga_read),
        .vga_adr    (vga_adr),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data)
    );

    uart_rx_buffer #(
        .RX_DEPTH(RX_DEPTH)
    ) u_uart_rx (
        .clk      (clk),
        .nRst     (nRst),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .uart_pop (uart_pop),
        .rx_ready (rx_ready),
        .uart_word(uart_word)
    );

endmodule

// File: rtl/uart_rx_buffer.sv
`timescale 1ns/100ps

module uart_rx_buffer #(
    parameter int RX_DEPTH = 4
) (
    input  logic               clk,
    input  logic               nRst,
    input  logic               rx_valid,
    input  logic [7:0]         rx_byte,
    input  logic               uart_pop,
    output logic               rx_ready,
    output mem_bus_pkg::word_t uart_word
);
    localparam int PW = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int NW = $clog2(RX_DEPTH + 1);

    logic [7:0]    rx_mem [RX_DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [NW-1:0] count;
    logic          push;
    logic          pop;
    logic          not_empty;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(RX_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign rx_ready  = (count < NW'(RX_DEPTH));
    assign push      = rx_valid && rx_ready;
    // popping an empty buffer does nothing
    assign pop       = uart_pop && not_empty;

    // status flag on top, oldest byte at the bottom
    assign uart_word = {not_empty, 23'd0, rx_mem[head]};

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            count <= count + NW'(push) - NW'(pop);
            if (push) begin
                tail <= ptr_inc(tail);
            end
            if (pop) begin
                head <= ptr_inc(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            rx_mem[tail] <= rx_byte;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!nRst) count <= NW'(RX_DEPTH)
    ) else $error("uart buffer count above depth");

endmodule

// File: rtl/frame_fetcher.sv
`timescale 1ns/100ps

module frame_fetcher #(
    parameter mem_bus_pkg::addr_t FB_BASE     = 32'h400,
    parameter int                 FRAME_WORDS = 24,
    parameter int                 FIFO_DEPTH  = 4
) (
    input  logic                    clk,
    input  logic                    nRst,
    input  logic                    frame_start,
    input  logic                    vga_enable,
    input  mem_bus_pkg::word_t      data_to_vga,
    input  logic                    pix_ready,
    output display_pkg::vga_state_t vga_state,
    output logic                    vga_read,
    output mem_bus_pkg::addr_t      vga_adr,
    output logic                    pix_valid,
    output display_pkg::pix_word_t  pix_data
);
    import mem_bus_pkg::*;
    import display_pkg::*;

    localparam int CW = $clog2(FRAME_WORDS + 1);
    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int NW = $clog2(FIFO_DEPTH + 1);

    vga_state_t    state_next;
    logic [CW-1:0] word_cnt;
    logic [CW-1:0] word_next;
    logic          pending;
    logic [NW-1:0] count;
    logic [NW-1:0] count_next;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    pix_word_t     fifo_mem [FIFO_DEPTH];
    logic          push;
    logic          pop;
    logic          start;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // a word only counts if this fetcher asked for it
    assign push  = vga_enable && pending;
    assign pop   = pix_valid && pix_ready;
    assign start = frame_start && (word_cnt == CW'(FRAME_WORDS)) && (count == '0);

    assign count_next = count + NW'(push) - NW'(pop);

    assign vga_read  = pending;
    assign vga_adr   = FB_BASE + addr_t'({word_cnt, 2'b00});
    assign pix_valid = (count != '0);
    assign pix_data  = fifo_mem[rd_ptr];

    // demand only while the frame has words left and a slot can be reserved
    always_comb begin
        word_next = word_cnt;
        if (start) begin
            word_next = '0;
        end else if (push) begin
            word_next = word_cnt + 1'b1;
        end
        if (word_next < CW'(FRAME_WORDS) && count_next < NW'(FIFO_DEPTH)) begin
            state_next = (word_next == '0) ? READY : ACTIVE;
        end else begin
            state_next = INACTIVE;
        end
    end

    // word_cnt at FRAME_WORDS means no frame in progress
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            vga_state <= INACTIVE;
            pending   <= 1'b0;
            word_cnt  <= CW'(FRAME_WORDS);
            count     <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else begin
            vga_state <= state_next;
            pending   <= (state_next != INACTIVE);
            word_cnt  <= word_next;
            count     <= count_next;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= data_to_vga;
        end
    end

    a_fifo_no_overflow: assert property (
        @(posedge clk) disable iff (!nRst) push |-> (count < NW'(FIFO_DEPTH))
    ) else $error("pixel fifo overflow");

    a_pix_stable: assert property (
        @(posedge clk) disable iff (!nRst)
        (pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_data))
    ) else $error("pix_data changed while stalled");

endmodule

// File: rtl/wait_state_sram.sv
`timescale 1ns/100ps

module wait_state_sram #(
    parameter int MEM_WORDS   = 1024,
    parameter int WAIT_STATES = 2
) (
    input  logic                  clk,
    input  logic                  nRst,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_busy,
    output mem_bus_pkg::word_t    mem_rdata
);
    import mem_bus_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    word_t         mem_array [MEM_WORDS];
    logic [CW-1:0] wait_cnt;
    logic [AW-1:0] word_idx;
    logic          accept;

    // word index from the byte address
    assign word_idx = mem_req.adr[AW+1:2];

    assign mem_busy = (wait_cnt != '0);
    assign accept   = !mem_busy && (mem_req.read || mem_req.write);

    // busy for WAIT_STATES cycles after each accepted access
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wait_cnt <= '0;
        end else if (accept) begin
            wait_cnt <= CW'(WAIT_STATES);
        end else if (mem_busy) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // read data is taken at acceptance and held until the next read
    always_ff @(posedge clk) begin
        if (accept && mem_req.read) begin
            mem_rdata <= mem_array[word_idx];
        end
        if (accept && mem_req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_req.sel[i]) begin
                    mem_array[word_idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // the handler must never ask for read and write at once
    a_no_read_write: assert property (
        @(posedge clk) disable iff (!nRst)
        accept |-> !(mem_req.read && mem_req.write)
    ) else $error("accepted request with both read and write set");

endmodule

// File: rtl/request_handler.sv
`timescale 1ns/100ps

module request_handler #(
    parameter mem_bus_pkg::addr_t UART_ADDRESS = 32'd500
) (
    input  logic                    clk,
    input  logic                    nRst,

    // memory side
    input  logic                    mem_busy,
    input  mem_bus_pkg::word_t      mem_rdata,
    output mem_bus_pkg::mem_req_t   mem_req,

    // display fetcher
    input  display_pkg::vga_state_t vga_state,
    input  logic                    vga_read,
    input  mem_bus_pkg::addr_t      vga_adr,
    output mem_bus_pkg::word_t      data_to_vga,
    output logic                    vga_enable,

    // processor
    input  mem_bus_pkg::cpu_req_t   cpu_req,
    output mem_bus_pkg::word_t      instr_data_to_cpu,
    output mem_bus_pkg::word_t      data_to_cpu,
    output logic                    cpu_enable,

    // uart receive buffer
    input  mem_bus_pkg::word_t      uart_word,
    output logic                    uart_pop
);
    import mem_bus_pkg::*;
    import display_pkg::*;

    // client being issued to memory and client being answered
    client_t issue_client;
    client_t answer_client;
    client_t issue_after;

    word_t instr_word;
    logic  vga_issued;
    logic  uart_access;
    logic  fetch_hold;

    assign uart_access = (cpu_req.data_adr == UART_ADDRESS);

    // the next instruction address only shows up after cpu_enable
    assign fetch_hold = (answer_client == CPU_DATA) && (issue_client == CPU_INSTR);

    // display slot is skipped while the fetcher wants nothing
    always_comb begin
        case (issue_client)
            VGA_CLIENT: issue_after = CPU_INSTR;
            CPU_INSTR:  issue_after = CPU_DATA;
            default:    issue_after = (vga_state == INACTIVE) ? CPU_INSTR : VGA_CLIENT;
        endcase
    end

    // rotation only moves on the cycle that memory is idle
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            issue_client  <= VGA_CLIENT;
            answer_client <= VGA_CLIENT;
            vga_issued    <= 1'b0;
        end else if (!mem_busy) begin
            answer_client <= issue_client;
            vga_issued    <= (issue_client == VGA_CLIENT) && vga_read;
            if (!fetch_hold) begin
                issue_client <= issue_after;
            end
        end
    end

    // last fetched instruction, handed over with the data slot
    always_ff @(posedge clk) begin
        if (!mem_busy && answer_client == CPU_INSTR) begin
            instr_word <= mem_rdata;
        end
    end

    // request for the client being issued
    always_comb begin
        mem_req = '0;
        if (!mem_busy) begin
            case (issue_client)
                VGA_CLIENT: begin
                    mem_req.read = vga_read;
                    mem_req.adr  = vga_adr;
                    mem_req.sel  = '1;
                end
                CPU_INSTR: begin
                    mem_req.read = !fetch_hold;
                    mem_req.adr  = cpu_req.instr_adr;
                    mem_req.sel  = '1;
                end
                default: begin
                    // uart access stays off the memory port
                    if (!uart_access) begin
                        mem_req.read  = cpu_req.read;
                        mem_req.write = cpu_req.write;
                        mem_req.adr   = cpu_req.data_adr;
                        mem_req.wdata = cpu_req.wdata;
                        mem_req.sel   = cpu_req.sel;
                    end
                end
            endcase
        end
    end

    // response steering
    assign vga_enable = !mem_busy && (answer_client == VGA_CLIENT) && vga_issued;
    assign cpu_enable = !mem_busy && (answer_client == CPU_DATA);
    assign uart_pop   = cpu_enable && uart_access && cpu_req.read;

    assign data_to_vga       = vga_enable ? mem_rdata : '0;
    assign instr_data_to_cpu = instr_word;

    always_comb begin
        if (!cpu_enable) begin
            data_to_cpu = '0;
        end else if (uart_access) begin
            data_to_cpu = uart_word;
        end else begin
            data_to_cpu = mem_rdata;
        end
    end

    // cpu_enable is a single-cycle pulse
    a_enable_pulse: assert property (
        @(posedge clk) disable iff (!nRst) cpu_enable |=> !cpu_enable
    ) else $error("cpu_enable high for two cycles");

    // uart data slot ends after one cycle
    a_uart_one_cycle: assert property (
        @(posedge clk) disable iff (!nRst)
        (!mem_busy && issue_client == CPU_DATA && uart_access) |=> cpu_enable
    ) else $error("uart data slot did not end after one cycle");

endmodule

// File: rtl/display_pkg.sv
package display_pkg;

    // bus demand of the display fetcher
    //   INACTIVE  no word wanted
    //   READY     first word of a frame wanted
    //   ACTIVE    a later word of the frame wanted
    typedef enum logic [1:0] {
        INACTIVE = 2'd0,
        READY    = 2'd1,
        ACTIVE   = 2'd2
    } vga_state_t;

    // two 16-bit pixels packed in one word
    typedef logic [31:0] pix_word_t;

endpackage

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    // 32-bit data word on the shared port
    typedef logic [31:0] word_t;

    // byte address as seen by every client
    typedef logic [31:0] addr_t;

    // one enable per byte lane
    typedef logic [3:0] sel_t;

    // owner of a memory slot
    typedef enum logic [1:0] {
        VGA_CLIENT = 2'd0,
        CPU_INSTR  = 2'd2,
        CPU_DATA   = 2'd3
    } client_t;

    // request as presented to the memory port
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t adr;
        word_t wdata;
        sel_t  sel;
    } mem_req_t;

    // processor request, held until cpu_enable
    typedef struct packed {
        addr_t instr_adr;
        addr_t data_adr;
        logic  read;
        logic  write;
        word_t wdata;
        sel_t  sel;
    } cpu_req_t;

endpackage
